// File: card_game_top.f
+incdir+include
rtl/card_game_pkg.sv
rtl/card_if.sv
rtl/turn_ctrl.sv
rtl/card_lfsr.sv
rtl/card_decode.sv
rtl/card_table.sv
rtl/bell_judge.sv
rtl/card_game_top.sv
test/tb_card_game.sv

// File: test/tb_card_game.sv
`timescale 1ns/100ps
`include "card_game_config.svh"

module tb_card_game;
    import card_game_pkg::*;

    // upper bound on cycles spent playing
    localparam int RUN_LIMIT = 4000;

    logic       clk = 1'b0;
    logic       rst;
    logic [3:0] keypad_in;

    logic       draw_en;
    player_t    whose;
    color_t     p1_color;
    number_t    p1_number;
    color_t     p2_color;
    number_t    p2_number;
    logic [7:0] draw_count;
    logic       game_over;
    logic       bell_ok;
    logic       bell_bad;
    player_t    bell_player;

    // reference model state updated once per cycle
    player_t    m_whose;
    player_t    m_pend;
    player_t    m_drawer;
    player_t    m_bell_player;
    logic       m_draw_en;
    logic       m_valid;
    logic       m_game_over;
    logic       m_bell_ok;
    logic       m_bell_bad;
    logic [4:0] m_lfsr;
    card_t      m_card;
    card_t      m_p1;
    card_t      m_p2;
    logic [7:0] m_count;

    logic       model_ready = 1'b0;
    logic       check_on = 1'b0;
    logic       in_reset_q = 1'b0;
    int         games_done = 0;

    int err_reset = 0;
    int err_turn = 0;
    int err_card = 0;
    int err_count = 0;
    int err_bell = 0;
    int err_timeout = 0;

    // all outputs packed so the reset state reads as zero
    logic [23:0] reset_vec;
    assign reset_vec = {draw_en, whose, p1_color, p1_number, p2_color, p2_number,
                        draw_count, game_over, bell_ok, bell_bad, bell_player};

    always #2 clk = ~clk;

    card_game_top uut (
        .clk         (clk),
        .rst         (rst),
        .keypad_in   (keypad_in),
        .draw_en     (draw_en),
        .whose       (whose),
        .p1_color    (p1_color),
        .p1_number   (p1_number),
        .p2_color    (p2_color),
        .p2_number   (p2_number),
        .draw_count  (draw_count),
        .game_over   (game_over),
        .bell_ok     (bell_ok),
        .bell_bad    (bell_bad),
        .bell_player (bell_player)
    );

    // one lfsr step shifts left and feeds in bit 2 xor bit 4
    function automatic logic [4:0] lfsr_step(input logic [4:0] s);
        return {s[3:0], s[2] ^ s[4]};
    endfunction

    // color cycles 1..3 with 11 back to 1
    // number is rnd mod 5 plus 1
    function automatic card_t card_of(input logic [4:0] r);
        card_t c;
        c.color  = (r[4:3] == 2'b11) ? 2'd1 : 2'(r[4:3] + 2'd1);
        c.number = 3'((r[2:0] % 5) + 1);
        return c;
    endfunction

    function automatic logic [3:0] end_key_for(input player_t p);
        return (p == player1) ? `KEY_END_P1 : `KEY_END_P2;
    endfunction

    // pair of one color summing to the target or any five
    function automatic logic bell_rule_holds(input card_t a, input card_t b);
        int sum;
        sum = int'(a.number) + int'(b.number);
        return ((a.color != 2'd0) && (b.color != 2'd0) && (a.color == b.color) &&
                (sum == `BELL_SUM)) || (a.number == 3'd5) || (b.number == 3'd5);
    endfunction

    // mostly game keys and a few arbitrary codes
    function automatic logic [3:0] pick_key();
        int unsigned roll;
        roll = $urandom_range(99, 0);
        if (roll < 30) return `KEY_END_P1;
        if (roll < 60) return `KEY_END_P2;
        if (roll < 75) return `KEY_BELL_P1;
        if (roll < 90) return `KEY_BELL_P2;
        return 4'($urandom_range(15, 0));
    endfunction

    always @(posedge clk) begin
        in_reset_q <= !rst;
        check_on   <= model_ready;
    end

    always @(posedge clk) begin
        if (!rst) begin
            model_ready   <= 1'b1;
            m_whose       <= player1;
            m_pend        <= player1;
            m_draw_en     <= 1'b0;
            m_lfsr        <= `LFSR_SEED;
            m_valid       <= 1'b0;
            m_card        <= '0;
            m_drawer      <= player1;
            m_p1          <= '0;
            m_p2          <= '0;
            m_count       <= 8'd0;
            m_game_over   <= 1'b0;
            m_bell_ok     <= 1'b0;
            m_bell_bad    <= 1'b0;
            m_bell_player <= player1;
        end else begin
            m_lfsr <= lfsr_step(m_lfsr);
            // turn passes on the player's own end key but never during a draw pulse
            if ((keypad_in == end_key_for(m_whose)) && !m_draw_en) begin
                m_draw_en <= 1'b1;
                m_pend    <= m_whose;
                m_whose   <= (m_whose == player1) ? player2 : player1;
            end else begin
                m_draw_en <= 1'b0;
            end
            // card taken from the lfsr value shown during the pulse
            m_valid <= m_draw_en;
            if (m_draw_en) begin
                m_card   <= card_of(lfsr_step(m_lfsr));
                m_drawer <= m_pend;
            end
            // table is cleared the cycle after the game ends
            if (m_game_over) begin
                m_p1        <= '0;
                m_p2        <= '0;
                m_count     <= 8'd0;
                m_game_over <= 1'b0;
                games_done  <= games_done + 1;
            end else if (m_valid) begin
                if (m_drawer == player1) begin
                    m_p1 <= m_card;
                end else begin
                    m_p2 <= m_card;
                end
                m_count     <= m_count + 8'd1;
                m_game_over <= ((m_count + 8'd1) == `GAME_DRAWS);
            end else begin
                m_game_over <= 1'b0;
            end
            // bell verdict on the slots of this cycle
            m_bell_ok  <= ((keypad_in == `KEY_BELL_P1) || (keypad_in == `KEY_BELL_P2)) &&
                          bell_rule_holds(m_p1, m_p2);
            m_bell_bad <= ((keypad_in == `KEY_BELL_P1) || (keypad_in == `KEY_BELL_P2)) &&
                          !bell_rule_holds(m_p1, m_p2);
            if (keypad_in == `KEY_BELL_P1) begin
                m_bell_player <= player1;
            end else if (keypad_in == `KEY_BELL_P2) begin
                m_bell_player <= player2;
            end
        end
    end

    reset_values: assert property (@(posedge clk) in_reset_q |-> reset_vec == 24'h0)
        else begin
            err_reset++;
            $display("Mismatch reset outputs: got %h expected %h", $sampled(reset_vec), 24'h0);
        end

    whose_model: assert property (@(posedge clk) check_on |-> whose == m_whose)
        else begin
            err_turn++;
            $display("Mismatch whose: got %h expected %h", $sampled(whose), $sampled(m_whose));
        end

    draw_en_model: assert property (@(posedge clk) check_on |-> draw_en == m_draw_en)
        else begin
            err_turn++;
            $display("Mismatch draw_en: got %h expected %h",
                     $sampled(draw_en), $sampled(m_draw_en));
        end

    // the turn only moves together with a draw pulse
    turn_moves_with_draw: assert property (
        @(posedge clk) check_on && (whose != $past(whose)) |-> draw_en)
        else begin
            err_turn++;
            $display("whose changed without a draw pulse");
        end

    p1_model: assert property (@(posedge clk) check_on |-> {p1_color, p1_number} == m_p1)
        else begin
            err_card++;
            $display("Mismatch p1 card: got %h expected %h",
                     $sampled({p1_color, p1_number}), $sampled(m_p1));
        end

    p2_model: assert property (@(posedge clk) check_on |-> {p2_color, p2_number} == m_p2)
        else begin
            err_card++;
            $display("Mismatch p2 card: got %h expected %h",
                     $sampled({p2_color, p2_number}), $sampled(m_p2));
        end

    count_model: assert property (@(posedge clk) check_on |-> draw_count == m_count)
        else begin
            err_count++;
            $display("Mismatch draw_count: got %h expected %h",
                     $sampled(draw_count), $sampled(m_count));
        end

    game_over_model: assert property (@(posedge clk) check_on |-> game_over == m_game_over)
        else begin
            err_count++;
            $display("Mismatch game_over: got %h expected %h",
                     $sampled(game_over), $sampled(m_game_over));
        end

    // a new game starts from an empty table
    game_clears: assert property (
        @(posedge clk) check_on && game_over |=>
        (draw_count == 8'd0) && ({p1_color, p1_number} == 5'd0) &&
        ({p2_color, p2_number} == 5'd0))
        else begin
            err_count++;
            $display("table not cleared one cycle after game_over");
        end

    bell_ok_model: assert property (@(posedge clk) check_on |-> bell_ok == m_bell_ok)
        else begin
            err_bell++;
            $display("Mismatch bell_ok: got %h expected %h",
                     $sampled(bell_ok), $sampled(m_bell_ok));
        end

    bell_bad_model: assert property (@(posedge clk) check_on |-> bell_bad == m_bell_bad)
        else begin
            err_bell++;
            $display("Mismatch bell_bad: got %h expected %h",
                     $sampled(bell_bad), $sampled(m_bell_bad));
        end

    bell_player_model: assert property (
        @(posedge clk) check_on && (m_bell_ok || m_bell_bad) |-> bell_player == m_bell_player)
        else begin
            err_bell++;
            $display("Mismatch bell_player: got %h expected %h",
                     $sampled(bell_player), $sampled(m_bell_player));
        end

    bell_single: assert property (@(posedge clk) check_on |-> !(bell_ok && bell_bad))
        else begin
            err_bell++;
            $display("bell_ok and bell_bad high in the same cycle");
        end

    initial begin
        int cycles;
        int total;
        void'($urandom(32'hc873_fe17));
        rst       = 1'b0;
        keypad_in = 4'h0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        // random keys until two games have ended
        cycles = 0;
        while ((games_done < 2) && (cycles < RUN_LIMIT)) begin
            @(posedge clk);
            keypad_in <= pick_key();
            cycles++;
        end
        if (games_done < 2) begin
            err_timeout++;
            $display("timeout: only %0d of 2 games finished after %0d cycles",
                     games_done, cycles);
        end
        @(posedge clk);
        keypad_in <= 4'h0;
        // last draw lands by k+4
        repeat (6) @(posedge clk);
        total = err_reset + err_turn + err_card + err_count + err_bell + err_timeout;
        $display("errors: reset %0d turn %0d card %0d count %0d bell %0d timeout %0d",
                 err_reset, err_turn, err_card, err_count, err_bell, err_timeout);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/card_game_top.sv
`timescale 1ns/100ps

module card_game_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [3:0]              keypad_in,
    output logic                    draw_en,
    output card_game_pkg::player_t  whose,
    output card_game_pkg::color_t   p1_color,
    output card_game_pkg::number_t  p1_number,
    output card_game_pkg::color_t   p2_color,
    output card_game_pkg::number_t  p2_number,
    output logic [7:0]              draw_count,
    output logic                    game_over,
    output logic                    bell_ok,
    output logic                    bell_bad,
    output card_game_pkg::player_t  bell_player
);
    import card_game_pkg::*;

    logic [4:0] rnd;
    card_t      p1_card;
    card_t      p2_card;

    // decoder to table
    card_if drw ();

    // turn handling, one draw per accepted end key
    turn_ctrl u_turn (
        .clk       (clk),
        .rst       (rst),
        .keypad_in (keypad_in),
        .draw_en   (draw_en),
        .whose     (whose)
    );

    card_lfsr u_lfsr (
        .clk     (clk),
        .rst     (rst),
        .draw_en (draw_en),
        .rnd     (rnd)
    );

    card_decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .draw_en (draw_en),
        .whose   (whose),
        .rnd     (rnd),
        .drw     (drw.source)
    );

    // slots and draw counter
    card_table u_table (
        .clk       (clk),
        .rst       (rst),
        .drw       (drw.sink),
        .p1_card   (p1_card),
        .p2_card   (p2_card),
        .game_over (game_over)
    );

    // bell sees the same slots the players see
    bell_judge u_bell (
        .clk         (clk),
        .rst         (rst),
        .keypad_in   (keypad_in),
        .p1_card     (p1_card),
        .p2_card     (p2_card),
        .bell_ok     (bell_ok),
        .bell_bad    (bell_bad),
        .bell_player (bell_player)
    );

    // split the slots for the top-level ports
    assign p1_color   = p1_card.color;
    assign p1_number  = p1_card.number;
    assign p2_color   = p2_card.color;
    assign p2_number  = p2_card.number;
    assign draw_count = drw.draw_count;

endmodule

// File: rtl/bell_judge.sv
`timescale 1ns/100ps
`include "card_game_config.svh"

module bell_judge (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [3:0]             keypad_in,
    input  card_game_pkg::card_t   p1_card,
    input  card_game_pkg::card_t   p2_card,
    output logic                   bell_ok,
    output logic                   bell_bad,
    output card_game_pkg::player_t bell_player
);
    import card_game_pkg::*;

    logic       ring_p1;
    logic       ring_p2;
    logic       both_up;
    logic       same_color;
    logic [3:0] num_sum;
    logic       rule_hit;

    assign ring_p1 = (keypad_in == `KEY_BELL_P1);
    assign ring_p2 = (keypad_in == `KEY_BELL_P2);

    // both slots hold a card
    assign both_up = (p1_card.color != 2'd0) && (p2_card.color != 2'd0) &&
                     (p1_card.number != 3'd0) && (p2_card.number != 3'd0);

    assign same_color = (p1_card.color == p2_card.color);

    // widened so 5 + 5 does not wrap
    assign num_sum = {1'b0, p1_card.number} + {1'b0, p2_card.number};

    // matching pair summing to target, or any single five
    assign rule_hit = (both_up && same_color && (num_sum == `BELL_SUM)) ||
                      (p1_card.number == NUMBER_FIVE) ||
                      (p2_card.number == NUMBER_FIVE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            bell_ok     <= 1'b0;
            bell_bad    <= 1'b0;
            bell_player <= player1;
        end else begin
            // verdict on the slots seen at the key
            bell_ok  <= (ring_p1 || ring_p2) && rule_hit;
            bell_bad <= (ring_p1 || ring_p2) && !rule_hit;
            // who rang, kept until the next ring
            if (ring_p1) begin
                bell_player <= player1;
            end else if (ring_p2) begin
                bell_player <= player2;
            end
        end
    end

    // one verdict per ring, never both
    verdict_onehot: assert property (
        @(posedge clk) disable iff (!rst)
        !(bell_ok && bell_bad)
    );

endmodule

// File: rtl/card_table.sv
`timescale 1ns/100ps
`include "card_game_config.svh"

module card_table (
    input  logic                 clk,
    input  logic                 rst,
    card_if.sink                 drw,
    output card_game_pkg::card_t p1_card,
    output card_game_pkg::card_t p2_card,
    output logic                 game_over
);
    import card_game_pkg::*;

    // face-up card per player
    card_t      p1_q;
    card_t      p2_q;
    // draws in the current game
    logic [7:0] count_q;
    logic       last_draw;

    // count sits at the limit in the end-of-game cycle
    assign last_draw = (count_q == `GAME_DRAWS);

    always_ff @(posedge clk) begin
        if (!rst) begin
            p1_q    <= CARD_EMPTY;
            p2_q    <= CARD_EMPTY;
            count_q <= 8'd0;
        end else if (last_draw) begin
            // new game starts on a clean table
            // next valid comes a cycle later at the earliest so none is lost here
            p1_q    <= CARD_EMPTY;
            p2_q    <= CARD_EMPTY;
            count_q <= 8'd0;
        end else if (drw.valid) begin
            // registered demux on the drawing player
            if (drw.whose == player1) begin
                p1_q <= drw.card;
            end else begin
                p2_q <= drw.card;
            end
            count_q <= count_q + 8'd1;
        end
    end

    assign p1_card        = p1_q;
    assign p2_card        = p2_q;
    assign drw.draw_count = count_q;

    // high for the one cycle the count sits at the limit
    assign game_over = last_draw;

    // clear must catch the count before it passes the limit
    count_bounded: assert property (
        @(posedge clk) disable iff (!rst)
        count_q <= `GAME_DRAWS
    );

endmodule

// File: rtl/card_decode.sv
`timescale 1ns/100ps

module card_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   draw_en,
    input  card_game_pkg::player_t whose,
    input  logic [4:0]             rnd,
    card_if.source                 drw
);
    import card_game_pkg::*;

    card_t   card_nxt;
    player_t drawer;

    always_comb begin
        // color from rnd[4:3], 11 folds back to 1
        case (rnd[4:3])
            2'b00:   card_nxt.color = 2'd1;
            2'b01:   card_nxt.color = 2'd2;
            2'b10:   card_nxt.color = 2'd3;
            default: card_nxt.color = 2'd1;
        endcase
        // number from rnd[2:0], 5..7 wrap to 1..3
        case (rnd[2:0])
            3'b000:  card_nxt.number = 3'd1;
            3'b001:  card_nxt.number = 3'd2;
            3'b010:  card_nxt.number = 3'd3;
            3'b011:  card_nxt.number = 3'd4;
            3'b100:  card_nxt.number = 3'd5;
            3'b101:  card_nxt.number = 3'd1;
            3'b110:  card_nxt.number = 3'd2;
            default: card_nxt.number = 3'd3;
        endcase
    end

    // turn has already flipped when draw_en shows up
    assign drawer = (whose == player1) ? player2 : player1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            drw.valid <= 1'b0;
        end else begin
            drw.valid <= draw_en;
        end
    end

    // card payload, only loaded on a draw
    always_ff @(posedge clk) begin
        if (draw_en) begin
            drw.card  <= card_nxt;
            drw.whose <= drawer;
        end
    end

    // any card put on the interface is a real card
    card_legal: assert property (
        @(posedge clk) disable iff (!rst)
        drw.valid |-> (drw.card.color != 2'd0) &&
                      (drw.card.number >= 3'd1) && (drw.card.number <= 3'd5)
    );

endmodule

// File: rtl/card_lfsr.sv
`timescale 1ns/100ps
`include "card_game_config.svh"

module card_lfsr (
    input  logic       clk,
    input  logic       rst,
    input  logic       draw_en,
    output logic [4:0] rnd
);
    import card_game_pkg::*;

    // running state and the value held from the last draw
    logic [4:0] lfsr_q;
    logic [4:0] lfsr_nxt;
    logic [4:0] hold_q;
    logic [4:0] hold_nxt;

    always_comb begin
        // shift left, feedback from taps 4 and 2
        lfsr_nxt    = {lfsr_q[3:0], 1'b0};
        lfsr_nxt[0] = lfsr_q[2] ^ lfsr_q[4];
        // capture on a draw, keep otherwise
        hold_nxt    = draw_en ? lfsr_nxt : hold_q;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            lfsr_q <= `LFSR_SEED;
            hold_q <= 5'd0;
        end else begin
            // free running, one step per cycle
            lfsr_q <= lfsr_nxt;
            hold_q <= hold_nxt;
        end
    end

    // during the draw the decoder sees the fresh value directly
    assign rnd = draw_en ? lfsr_nxt : hold_q;

    // a zero state would lock the lfsr for good
    lfsr_nonzero: assert property (
        @(posedge clk) disable iff (!rst)
        lfsr_q != 5'd0
    );

endmodule

// File: rtl/turn_ctrl.sv
`timescale 1ns/100ps
`include "card_game_config.svh"

module turn_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [3:0]            keypad_in,
    output logic                  draw_en,
    output card_game_pkg::player_t whose
);
    import card_game_pkg::*;

    typedef enum logic {
        st_p1 = 1'b0,
        st_p2 = 1'b1
    } state_t;

    state_t state;
    logic   end_key;
    logic   accept;

    // only the player on turn can end it
    assign end_key = (state == st_p1) ? (keypad_in == `KEY_END_P1)
                                      : (keypad_in == `KEY_END_P2);

    // no key taken in the draw cycle itself
    // keeps draws at least two cycles apart
    assign accept = end_key && !draw_en;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= st_p1;
            draw_en <= 1'b0;
        end else begin
            draw_en <= accept;
            if (accept) begin
                // hand the turn over
                state <= (state == st_p1) ? st_p2 : st_p1;
            end
        end
    end

    // whose flips together with the draw pulse
    // so during draw_en it already names the next player
    assign whose = (state == st_p2) ? player2 : player1;

    // draw pulse is one cycle wide and never back to back
    draw_en_single: assert property (
        @(posedge clk) disable iff (!rst)
        draw_en |=> !draw_en
    );

endmodule

// File: rtl/card_if.sv
`timescale 1ns/100ps

// one decoded draw on its way from the decoder to the table
interface card_if;
    import card_game_pkg::*;

    // single-cycle strobe, no back-pressure
    logic       valid;
    // player who drew the card
    player_t    whose;
    // the drawn card
    // whose and card only mean something while valid is high
    card_t      card;
    // draws so far in this game, from the table
    logic [7:0] draw_count;

    // decoder side
    modport source (
        output valid,
        output whose,
        output card,
        input  draw_count
    );

    // table side, always accepts
    modport sink (
        input  valid,
        input  whose,
        input  card,
        output draw_count
    );

endinterface

// File: rtl/card_game_pkg.sv
package card_game_pkg;

    // card color
    // 0 = empty slot, 1..3 = colors
    typedef logic [1:0] color_t;

    // card number
    // 0 = empty slot, 1..5 = numbers
    typedef logic [2:0] number_t;

    // player tag
    typedef enum logic {
        player1 = 1'b0,
        player2 = 1'b1
    } player_t;

    // one card, 5 bits total
    // color in the upper bits, as the slot outputs show it
    typedef struct packed {
        color_t  color;
        number_t number;
    } card_t;

    // nothing on the table
    localparam card_t CARD_EMPTY = '{color: 2'd0, number: 3'd0};

    // a single five rings the bell by itself
    localparam number_t NUMBER_FIVE = 3'd5;

endpackage

// File: include/card_game_config.svh
`ifndef CARD_GAME_CONFIG_SVH
`define CARD_GAME_CONFIG_SVH

// keypad codes, 4-bit
// player 1 ends the turn
`define KEY_END_P1  4'b0011
// player 2 ends the turn
`define KEY_END_P2  4'b0001
// player 1 rings the bell
`define KEY_BELL_P1 4'b0100
// player 2 rings the bell
`define KEY_BELL_P2 4'b0101

// lfsr reset value, must be nonzero
`define LFSR_SEED   5'b11100

// draws per game
// game ends when draw_count reaches this
`define GAME_DRAWS  8'd40

// target sum of the two face-up numbers
// 4 bits wide, sum of two numbers goes up to 10
`define BELL_SUM    4'd5

`endif
